// File: verilog.f
common/gc_pkg.sv
common/label_port_if.sv
garbler/label_gen.sv
garbler/label_store.sv
garbler/garble_ctrl.sv
garbler/free_xor_unit.sv
src/gc_garbler.sv
dv/tb_clock.sv
dv/gc_garbler_props.sv
dv/tb_gc_garbler.sv

// File: run_sim.sh
#!/bin/sh
# Builds the garbler testbench with Verilator and runs it
# The exit status is nonzero when the simulation ends in $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_gc_garbler \
	-f verilog.f \
	-o sim_tb_gc_garbler

./obj_dir/sim_tb_gc_garbler

// File: dv/tb_gc_garbler.sv
// Testbench for the free-XOR garbler, three runs of directed and random gate streams
// A reference model of the lanes and both stores predicts every output record in order

`timescale 1ns/10ps
`default_nettype none

module tb_gc_garbler;
	import gc_pkg::*;

	localparam int DIRECTED_GATES  = 7;
	localparam int CHAIN_LEN       = 12;
	localparam int RUN2_GATES      = 4;
	localparam int RANDOM_GATES    = 200;
	localparam int NUM_RUNS        = 3;
	localparam int TOTAL_GATES     = DIRECTED_GATES + CHAIN_LEN + RUN2_GATES + RANDOM_GATES;
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_GATES + 100 * NUM_RUNS;

	typedef struct packed {
		tag_e               tag;
		logic [WIRE_W-1:0]  idx0;
		logic [WIRE_W-1:0]  idx1;
		logic [LABEL_W-1:0] d0;
		logic [LABEL_W-1:0] d1;
		logic               use0; // data0 carries a defined value
		logic               use1;
	} rec_t;

	logic               clk;
	logic               rst;
	logic               start;
	logic               gate_valid;
	gate_op_e           gate_op;
	logic [WIRE_W-1:0]  gate_in0;
	logic [WIRE_W-1:0]  gate_in1;
	logic               gate_in0_pi;
	logic               gate_in1_pi;
	logic               gate_is_output;
	logic               gate_last;
	logic               gate_ready;
	tag_e               tag;
	logic [WIRE_W-1:0]  index0;
	logic [WIRE_W-1:0]  index1;
	logic [LABEL_W-1:0] data0;
	logic [LABEL_W-1:0] data1;

	// Reference model state
	logic [LABEL_W-1:0]   lane0;
	logic [LABEL_W-1:0]   lane1;
	logic [LABEL_W-1:0]   r_mdl;
	logic [NUM_WIRES-1:0] pi_written;
	logic [LABEL_W-1:0]   pi_lbl [NUM_WIRES];
	logic [LABEL_W-1:0]   gate_lbl [NUM_WIRES];
	logic [LABEL_W-1:0]   mdl_mask;
	logic [WIRE_W-1:0]    mdl_count;
	logic [WIRE_W-1:0]    mdl_gid;

	rec_t               exp_q [$];
	string              name_q [$];
	string              cur_test;
	rec_t               exp_rec;
	string              exp_name;
	logic [31:0]        rnd;
	logic [WIRE_W-1:0]  flagged;
	gate_op_e           r_op;
	logic [WIRE_W-1:0]  r_in0;
	logic [WIRE_W-1:0]  r_in1;
	logic               r_pi0;
	logic               r_pi1;

	tb_clock u_clock (.clk(clk), .rst(rst));

	gc_garbler UUT (
		.clk(clk), .rst(rst), .start(start),
		.gate_valid(gate_valid), .gate_op(gate_op),
		.gate_in0(gate_in0), .gate_in1(gate_in1),
		.gate_in0_pi(gate_in0_pi), .gate_in1_pi(gate_in1_pi),
		.gate_is_output(gate_is_output), .gate_last(gate_last),
		.gate_ready(gate_ready), .tag(tag),
		.index0(index0), .index1(index1), .data0(data0), .data1(data1)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_tag(input string name, input tag_e exp, input tag_e act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %s (%0d), actual %s (%0d)",
				name, exp.name(), exp, act.name(), act);
			abort_run("Output tag mismatch");
		end
	endtask

	task automatic check_index(input string name, input logic [WIRE_W-1:0] exp,
		input logic [WIRE_W-1:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
			abort_run("Index mismatch");
		end
	endtask

	task automatic check_label(input string name, input logic [LABEL_W-1:0] exp,
		input logic [LABEL_W-1:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run("Label mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			abort_run("Flag mismatch");
		end
	endtask

	// xorshift32 with the shift triple 13, 17, 5
	function automatic logic [LABEL_W-1:0] next_lane(input logic [LABEL_W-1:0] s);
		logic [LABEL_W-1:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Free-XOR output label of one gate
	function automatic logic [LABEL_W-1:0] gate_label(input gate_op_e op,
		input logic [LABEL_W-1:0] a, input logic [LABEL_W-1:0] b,
		input logic [LABEL_W-1:0] r);
		case (op)
			GATE_XOR:  return a ^ b;
			GATE_XNOR: return a ^ b ^ r;
			default:   return a ^ r;
		endcase
	endfunction

	function automatic gate_op_e pick_op(input logic [1:0] k);
		case (k)
			2'd0:    return GATE_XOR;
			2'd1:    return GATE_XNOR;
			default: return GATE_NOT;
		endcase
	endfunction

	function automatic logic is_const(input logic [WIRE_W-1:0] n);
		return (n == CONST_ZERO) || (n == CONST_ONE);
	endfunction

	function automatic logic [WIRE_W-1:0] random_pi();
		logic [31:0] r;
		r = $urandom % 40;
		if (r == 32'd38)
			return CONST_ZERO;
		if (r == 32'd39)
			return CONST_ONE;
		return r[WIRE_W-1:0];
	endfunction

	function automatic logic [WIRE_W-1:0] random_gate();
		logic [31:0] r;
		r = $urandom % 32'(mdl_gid); // Any earlier gate of this run
		return r[WIRE_W-1:0];
	endfunction

	task automatic push_rec(input tag_e t, input logic [WIRE_W-1:0] i0,
		input logic [WIRE_W-1:0] i1, input logic [LABEL_W-1:0] d0,
		input logic [LABEL_W-1:0] d1, input logic u0, input logic u1);
		rec_t r;
		r.tag  = t;
		r.idx0 = i0;
		r.idx1 = i1;
		r.d0   = d0;
		r.d1   = d1;
		r.use0 = u0;
		r.use1 = u1;
		exp_q.push_back(r);
		name_q.push_back(cur_test);
	endtask

	task automatic model_gate(input gate_op_e op, input logic [WIRE_W-1:0] in0,
		input logic pi0, input logic [WIRE_W-1:0] in1, input logic pi1,
		input logic is_out, input logic last);
		logic [WIRE_W-1:0]  a0;
		logic [WIRE_W-1:0]  a1;
		logic               n0;
		logic               n1;
		tag_e               t;
		logic [LABEL_W-1:0] l0;
		logic [LABEL_W-1:0] l1;
		logic [LABEL_W-1:0] res;
		a0 = in0 + CONST_OFFSET;
		a1 = in1 + CONST_OFFSET;
		n0 = pi0 && !pi_written[a0] && !is_const(in0);
		n1 = pi1 && (op != GATE_NOT) && !pi_written[a1] && !is_const(in1);
		if (n0 && n1)
			t = TAG_IN01;
		else if (n0)
			t = TAG_IN0;
		else
			t = TAG_IN1;
		if (n0 || n1)
			push_rec(t, n0 ? a0 : '1, n1 ? a1 : '1, lane0, lane1, n0, n1);
		if (n0) begin
			pi_lbl[a0]     = lane0;
			pi_written[a0] = 1'b1;
			lane0          = next_lane(lane0);
		end
		if (n1) begin
			pi_lbl[a1]     = lane1;
			pi_written[a1] = 1'b1;
			lane1          = next_lane(lane1);
		end
		l0  = pi0 ? pi_lbl[a0] : gate_lbl[in0];
		l1  = pi1 ? pi_lbl[a1] : gate_lbl[in1];
		res = gate_label(op, l0, l1, r_mdl);
		gate_lbl[mdl_gid] = res;
		mdl_gid = mdl_gid + 8'd1;
		if (is_out) begin
			mdl_mask[mdl_count[MASK_IDX_W-1:0]] = res[0];
			mdl_count = mdl_count + 8'd1;
		end
		if (last)
			push_rec(TAG_MASKS, '1, '1, mdl_mask, LABEL_W'(mdl_count), 1'b1, 1'b1);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready();
		while (!gate_ready)
			next_cycle();
	endtask

	// Pulses start in IDLE and predicts the key and constant records
	task automatic start_run();
		pi_written = '0;
		mdl_mask   = '0;
		mdl_count  = '0;
		mdl_gid    = '0;
		r_mdl      = {lane0[LABEL_W-1:1], 1'b1};
		push_rec(TAG_KEYS, '1, '1, r_mdl, lane1, 1'b1, 1'b1);
		lane0 = next_lane(lane0);
		pi_lbl[0]  = lane0;
		pi_lbl[1]  = lane1;
		pi_written[0] = 1'b1;
		pi_written[1] = 1'b1;
		push_rec(TAG_IN01, 8'd0, 8'd1, lane0, lane1, 1'b1, 1'b1);
		lane0 = next_lane(lane0);
		lane1 = next_lane(lane1);
		check_flag({cur_test, " ready in IDLE"}, 1'b0, gate_ready);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_flag({cur_test, " ready in KEYS"}, 1'b0, gate_ready);
		next_cycle();
		check_flag({cur_test, " ready in CONSTS"}, 1'b0, gate_ready);
		next_cycle();
		check_flag({cur_test, " ready in GARBLE"}, 1'b1, gate_ready);
	endtask

	task automatic send_gate(input gate_op_e op, input logic [WIRE_W-1:0] in0,
		input logic pi0, input logic [WIRE_W-1:0] in1, input logic pi1,
		input logic is_out, input logic last);
		wait_ready();
		model_gate(op, in0, pi0, in1, pi1, is_out, last);
		gate_valid     = 1'b1;
		gate_op        = op;
		gate_in0       = in0;
		gate_in0_pi    = pi0;
		gate_in1       = in1;
		gate_in1_pi    = pi1;
		gate_is_output = is_out;
		gate_last      = last;
		next_cycle();
		gate_valid = 1'b0;
		gate_last  = 1'b0;
		if (last)
			check_flag({cur_test, " ready after last gate"}, 1'b0, gate_ready);
	endtask

	task automatic finish_run();
		while (exp_q.size() != 0)
			next_cycle();
		next_cycle();
	endtask

	// Registered outputs are stable on the falling edge
	always @(negedge clk) begin
		if (!rst && tag != TAG_NONE) begin
			if (exp_q.size() == 0) begin
				abort_run($sformatf("Output record with tag %0d arrived unannounced", tag));
			end else begin
				exp_rec  = exp_q.pop_front();
				exp_name = name_q.pop_front();
				check_tag({exp_name, " tag"}, exp_rec.tag, tag);
				check_index({exp_name, " index0"}, exp_rec.idx0, index0);
				check_index({exp_name, " index1"}, exp_rec.idx1, index1);
				if (exp_rec.use0)
					check_label({exp_name, " data0"}, exp_rec.d0, data0);
				if (exp_rec.use1)
					check_label({exp_name, " data1"}, exp_rec.d1, data1);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Watchdog expired before the test sequence completed");
	end

	initial begin
		start          = 1'b0;
		gate_valid     = 1'b0;
		gate_op        = GATE_XOR;
		gate_in0       = '0;
		gate_in1       = '0;
		gate_in0_pi    = 1'b0;
		gate_in1_pi    = 1'b0;
		gate_is_output = 1'b0;
		gate_last      = 1'b0;
		rnd            = $urandom(32'hcc9c_fd4d);
		lane0          = SEED0;
		lane1          = SEED1;
		cur_test       = "reset";
		@(negedge rst);
		next_cycle();
		check_tag("reset tag", TAG_NONE, tag);
		check_index("reset index0", '1, index0);
		check_index("reset index1", '1, index1);
		check_flag("reset gate_ready", 1'b0, gate_ready);

		cur_test = "keys_consts";
		start_run();
		cur_test = "first_use";
		send_gate(GATE_XOR, 8'd0, 1'b1, 8'd1, 1'b1, 1'b1, 1'b0);
		send_gate(GATE_XOR, 8'd0, 1'b1, 8'd2, 1'b1, 1'b0, 1'b0);
		send_gate(GATE_XNOR, 8'd3, 1'b1, 8'd0, 1'b1, 1'b1, 1'b0);
		send_gate(GATE_XOR, 8'd1, 1'b1, 8'd0, 1'b1, 1'b1, 1'b0); // All labels exist
		cur_test = "const_ops";
		send_gate(GATE_XOR, CONST_ZERO, 1'b1, 8'd4, 1'b1, 1'b0, 1'b0);
		send_gate(GATE_XNOR, CONST_ONE, 1'b1, CONST_ZERO, 1'b1, 1'b1, 1'b0);
		send_gate(GATE_NOT, CONST_ONE, 1'b1, 8'd0, 1'b0, 1'b1, 1'b0);
		cur_test = "chain";
		for (int i = 0; i < CHAIN_LEN; i++)
			send_gate(pick_op(2'(i % 3)), mdl_gid - 8'd1, 1'b0, 8'(10 + i), 1'b1,
				1'b1, i == CHAIN_LEN - 1);
		finish_run();

		// Flags, mask and gate counter restart, the lanes keep going
		cur_test = "second_run";
		start_run();
		send_gate(GATE_XOR, 8'd0, 1'b1, 8'd1, 1'b1, 1'b1, 1'b0);
		send_gate(GATE_NOT, 8'd0, 1'b0, 8'd0, 1'b0, 1'b1, 1'b0);
		send_gate(GATE_XNOR, 8'd0, 1'b0, 8'd1, 1'b0, 1'b1, 1'b0);
		send_gate(GATE_XOR, 8'd2, 1'b0, 8'd0, 1'b1, 1'b1, 1'b1);
		finish_run();

		cur_test = "random";
		flagged  = '0;
		start_run();
		for (int k = 0; k < RANDOM_GATES; k++) begin
			rnd   = $urandom;
			r_op  = pick_op(2'($urandom % 3));
			r_pi0 = (mdl_gid == 8'd0) || rnd[0];
			r_pi1 = (mdl_gid == 8'd0) || rnd[1];
			r_in0 = r_pi0 ? random_pi() : random_gate();
			r_in1 = r_pi1 ? random_pi() : random_gate();
			if (r_op == GATE_NOT) begin
				r_pi1 = 1'b0;
				r_in1 = '0;
			end else if (r_pi0 && r_pi1 && r_in0 == r_in1) begin
				r_in1 = r_in0 ^ 8'd1;
			end
			if (rnd[2])
				flagged = flagged + 8'd1;
			send_gate(r_op, r_in0, r_pi0, r_in1, r_pi1, rnd[2], k == RANDOM_GATES - 1);
		end
		finish_run();
		check_index("random out_count", flagged, UUT.u_free_xor_unit.out_count);

		if (exp_q.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run("Expected output records never appeared");
		end
	end

endmodule

`default_nettype wire

// File: dv/gc_garbler_props.sv
// Concurrent checks on the garbler control, bound into every garble_ctrl instance
// Covers the gate stream handshake, the R register and the output stream reset value

`timescale 1ns/10ps
`default_nettype none

module gc_garbler_props (
	input logic                       clk,
	input logic                       rst,
	input gc_pkg::ctrl_state_e        state,
	input logic                       gate_ready,
	input logic                       gate_valid,
	input gc_pkg::gate_op_e           gate_op,
	input logic [gc_pkg::WIRE_W-1:0]  gate_in0,
	input logic [gc_pkg::WIRE_W-1:0]  gate_in1,
	input logic                       gate_in0_pi,
	input logic                       gate_in1_pi,
	input logic [gc_pkg::LABEL_W-1:0] r_label,
	input gc_pkg::tag_e               tag
);
	import gc_pkg::*;

	a_ready_in_garble: assert property (@(posedge clk) disable iff (rst)
		(state != GARBLE) |-> !gate_ready)
		else $error("gate_ready is high outside GARBLE");

	// Free-XOR relies on the point-and-permute bit of R
	a_r_lsb_set: assert property (@(posedge clk) disable iff (rst)
		(state == KEYS) |=> r_label[0])
		else $error("R bit 0 is clear after KEYS");

	a_pi_operands_differ: assert property (@(posedge clk) disable iff (rst)
		(gate_valid && gate_ready && gate_in0_pi && gate_in1_pi && gate_op != GATE_NOT)
		|-> (gate_in0 != gate_in1))
		else $error("Accepted gate names the same primary input twice");

	a_tag_idle_out_of_reset: assert property (@(posedge clk)
		$fell(rst) |-> (tag == TAG_NONE))
		else $error("Output tag is not TAG_NONE when reset is released");

endmodule

bind garble_ctrl gc_garbler_props u_props (
	.clk(clk), .rst(rst), .state(state),
	.gate_ready(gate_ready), .gate_valid(gate_valid), .gate_op(gate_op),
	.gate_in0(gate_in0), .gate_in1(gate_in1),
	.gate_in0_pi(gate_in0_pi), .gate_in1_pi(gate_in1_pi),
	.r_label(r_label), .tag(tag)
);

`default_nettype wire

// File: dv/tb_clock.sv
// Clock and reset source for the garbler testbench
// 8 ns clock, reset held high for the first two rising edges

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);
	localparam time HALF_PERIOD = 4ns;

	initial clk = 1'b0;
	always #(HALF_PERIOD) clk = ~clk;

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0; // Released just after the second edge
	end

endmodule

`default_nettype wire

// File: src/gc_garbler.sv
// Top level of the free-XOR garbler
// Gates enter on the gate_* strobe stream, evaluator data leaves on tag/index/data

`timescale 1ns/10ps
`default_nettype none

module gc_garbler (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic                       gate_valid,
	input  gc_pkg::gate_op_e           gate_op,
	input  logic [gc_pkg::WIRE_W-1:0]  gate_in0,
	input  logic [gc_pkg::WIRE_W-1:0]  gate_in1,
	input  logic                       gate_in0_pi,
	input  logic                       gate_in1_pi,
	input  logic                       gate_is_output,
	input  logic                       gate_last,
	output logic                       gate_ready,
	output gc_pkg::tag_e               tag,
	output logic [gc_pkg::WIRE_W-1:0]  index0,
	output logic [gc_pkg::WIRE_W-1:0]  index1,
	output logic [gc_pkg::LABEL_W-1:0] data0,
	output logic [gc_pkg::LABEL_W-1:0] data1
);
	import gc_pkg::*;

	logic               gen_en0;
	logic               gen_en1;
	logic [LABEL_W-1:0] label0;
	logic [LABEL_W-1:0] label1;
	logic [LABEL_W-1:0] r_label;
	logic               issue_valid;
	gate_op_e           issue_op;
	label_src_e         issue_src0;
	label_src_e         issue_src1;
	logic [WIRE_W-1:0]  issue_gid;
	logic               issue_is_output;
	logic [LABEL_W-1:0] mask;
	logic [WIRE_W-1:0]  out_count;

	label_port_if in_port ();   // Primary input and constant labels
	label_port_if gate_port (); // Gate output labels

	label_gen u_label_gen (
		.clk(clk), .rst(rst),
		.en0(gen_en0), .en1(gen_en1),
		.label0(label0), .label1(label1)
	);

	label_store in_store (.clk(clk), .rst(rst), .port(in_port));
	label_store gate_store (.clk(clk), .rst(rst), .port(gate_port));

	garble_ctrl u_garble_ctrl (
		.clk(clk), .rst(rst), .start(start),
		.gate_valid(gate_valid), .gate_op(gate_op),
		.gate_in0(gate_in0), .gate_in1(gate_in1),
		.gate_in0_pi(gate_in0_pi), .gate_in1_pi(gate_in1_pi),
		.gate_is_output(gate_is_output), .gate_last(gate_last),
		.label0(label0), .label1(label1),
		.in_port(in_port), .gate_rd(gate_port),
		.gate_ready(gate_ready),
		.gen_en0(gen_en0), .gen_en1(gen_en1),
		.r_label(r_label),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_src0(issue_src0), .issue_src1(issue_src1),
		.issue_gid(issue_gid), .issue_is_output(issue_is_output),
		.tag(tag), .index0(index0), .index1(index1),
		.data0(data0), .data1(data1),
		.mask(mask), .out_count(out_count)
	);

	free_xor_unit u_free_xor_unit (
		.clk(clk), .rst(rst), .r_label(r_label),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_src0(issue_src0), .issue_src1(issue_src1),
		.issue_gid(issue_gid), .issue_is_output(issue_is_output),
		.in_rd(in_port), .gate_port(gate_port),
		.clr_masks(start),
		.mask(mask), .out_count(out_count)
	);

endmodule

`default_nettype wire

// File: garbler/free_xor_unit.sv
// Computes free-XOR gate labels from the store read data and writes them back
// Also gathers bit 0 of every output gate label into the output mask

`timescale 1ns/10ps
`default_nettype none

module free_xor_unit (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [gc_pkg::LABEL_W-1:0] r_label,
	input  logic                       issue_valid,
	input  gc_pkg::gate_op_e           issue_op,
	input  gc_pkg::label_src_e         issue_src0,
	input  gc_pkg::label_src_e         issue_src1,
	input  logic [gc_pkg::WIRE_W-1:0]  issue_gid,
	input  logic                       issue_is_output,
	label_port_if.data                 in_rd,
	label_port_if.writer               gate_port,
	input  logic                       clr_masks,
	output logic [gc_pkg::LABEL_W-1:0] mask,
	output logic [gc_pkg::WIRE_W-1:0]  out_count
);
	import gc_pkg::*;

	logic [LABEL_W-1:0] in0_label;
	logic [LABEL_W-1:0] in1_label;
	logic [LABEL_W-1:0] out_label;

	assign in0_label = (issue_src0 == SRC_INPUT) ? in_rd.rd_data0 : gate_port.rd_data0;
	assign in1_label = (issue_src1 == SRC_INPUT) ? in_rd.rd_data1 : gate_port.rd_data1;

	always_comb begin
		case (issue_op)
			GATE_XOR:  out_label = in0_label ^ in1_label;
			GATE_XNOR: out_label = in0_label ^ in1_label ^ r_label;
			default:   out_label = in0_label ^ r_label; // NOT
		endcase
	end

	// Gate labels go out on port 0, port 1 stays idle
	assign gate_port.clr      = clr_masks;
	assign gate_port.wr_en0   = issue_valid;
	assign gate_port.wr_addr0 = issue_gid;
	assign gate_port.wr_data0 = out_label;
	assign gate_port.wr_en1   = 1'b0;
	assign gate_port.wr_addr1 = '1;
	assign gate_port.wr_data1 = '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mask      <= '0;
			out_count <= '0;
		end else if (clr_masks) begin
			mask      <= '0;
			out_count <= '0;
		end else if (issue_valid && issue_is_output) begin
			mask[out_count[MASK_IDX_W-1:0]] <= out_label[0];
			out_count                       <= out_count + WIRE_W'(1);
		end
	end

endmodule

`default_nettype wire

// File: garbler/garble_ctrl.sv
// Sequencer of a garbling run: keys, constant labels, gate acceptance and masks
// Generates missing input labels on demand, issues gates to the XOR unit and
// drives the registered tagged output stream

`timescale 1ns/10ps
`default_nettype none

module garble_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic                       gate_valid,
	input  gc_pkg::gate_op_e           gate_op,
	input  logic [gc_pkg::WIRE_W-1:0]  gate_in0,
	input  logic [gc_pkg::WIRE_W-1:0]  gate_in1,
	input  logic                       gate_in0_pi,
	input  logic                       gate_in1_pi,
	input  logic                       gate_is_output,
	input  logic                       gate_last,
	input  logic [gc_pkg::LABEL_W-1:0] label0,
	input  logic [gc_pkg::LABEL_W-1:0] label1,
	label_port_if.ctrl                 in_port,
	label_port_if.rd_addr              gate_rd,
	output logic                       gate_ready,
	output logic                       gen_en0,
	output logic                       gen_en1,
	output logic [gc_pkg::LABEL_W-1:0] r_label,
	output logic                       issue_valid,
	output gc_pkg::gate_op_e           issue_op,
	output gc_pkg::label_src_e         issue_src0,
	output gc_pkg::label_src_e         issue_src1,
	output logic [gc_pkg::WIRE_W-1:0]  issue_gid,
	output logic                       issue_is_output,
	output gc_pkg::tag_e               tag,
	output logic [gc_pkg::WIRE_W-1:0]  index0,
	output logic [gc_pkg::WIRE_W-1:0]  index1,
	output logic [gc_pkg::LABEL_W-1:0] data0,
	output logic [gc_pkg::LABEL_W-1:0] data1,
	input  logic [gc_pkg::LABEL_W-1:0] mask,
	input  logic [gc_pkg::WIRE_W-1:0]  out_count
);
	import gc_pkg::*;

	ctrl_state_e        state;
	ctrl_state_e        state_nxt;
	logic               accept;
	logic [WIRE_W-1:0]  addr0;
	logic [WIRE_W-1:0]  addr1;
	logic               need0;
	logic               need1;
	logic [WIRE_W-1:0]  gid;
	logic [LABEL_W-1:0] r_new;
	tag_e               tag_nxt;
	logic [WIRE_W-1:0]  index0_nxt;
	logic [WIRE_W-1:0]  index1_nxt;
	logic [LABEL_W-1:0] data0_nxt;
	logic [LABEL_W-1:0] data1_nxt;

	assign gate_ready = (state == GARBLE);
	assign accept     = gate_ready & gate_valid;
	assign r_new      = {label0[LABEL_W-1:1], 1'b1}; // Free-XOR needs R[0] set

	// Input addresses wrap, so CONST_ZERO and CONST_ONE hit entries 0 and 1
	assign addr0 = gate_in0 + CONST_OFFSET;
	assign addr1 = gate_in1 + CONST_OFFSET;

	assign in_port.rd_addr0 = addr0;
	assign in_port.rd_addr1 = addr1;
	assign gate_rd.rd_addr0 = gate_in0;
	assign gate_rd.rd_addr1 = gate_in1;

	// A label is generated on the first use of a primary input only
	assign need0 = accept & gate_in0_pi & ~in_port.written0
		& (gate_in0 != CONST_ZERO) & (gate_in0 != CONST_ONE);
	assign need1 = accept & gate_in1_pi & (gate_op != GATE_NOT) & ~in_port.written1
		& (gate_in1 != CONST_ZERO) & (gate_in1 != CONST_ONE);

	always_comb begin
		state_nxt        = state;
		in_port.clr      = 1'b0;
		gen_en0          = 1'b0;
		gen_en1          = 1'b0;
		in_port.wr_en0   = 1'b0;
		in_port.wr_en1   = 1'b0;
		in_port.wr_addr0 = addr0;
		in_port.wr_addr1 = addr1;
		in_port.wr_data0 = label0;
		in_port.wr_data1 = label1;
		tag_nxt          = TAG_NONE;
		index0_nxt       = '1;
		index1_nxt       = '1;
		data0_nxt        = label0;
		data1_nxt        = label1;

		case (state)
			IDLE: begin
				in_port.clr = start; // Fresh run forgets earlier input labels
				if (start)
					state_nxt = KEYS;
			end
			KEYS: begin
				gen_en0   = 1'b1;
				tag_nxt   = TAG_KEYS;
				data0_nxt = r_new; // data1 keeps lane 1 as second key material
				state_nxt = CONSTS;
			end
			CONSTS: begin
				gen_en0          = 1'b1;
				gen_en1          = 1'b1;
				in_port.wr_en0   = 1'b1;
				in_port.wr_en1   = 1'b1;
				in_port.wr_addr0 = '0;
				in_port.wr_addr1 = WIRE_W'(1);
				tag_nxt          = TAG_IN01;
				index0_nxt       = '0;
				index1_nxt       = WIRE_W'(1);
				state_nxt        = GARBLE;
			end
			GARBLE: begin
				gen_en0        = need0;
				gen_en1        = need1;
				in_port.wr_en0 = need0;
				in_port.wr_en1 = need1;
				if (need0 | need1) begin
					tag_nxt = tag_e'({1'b1, need1, need0});
					if (need0)
						index0_nxt = addr0;
					if (need1)
						index1_nxt = addr1;
				end
				if (accept & gate_last)
					state_nxt = DRAIN;
			end
			DRAIN: state_nxt = MASKS; // Last mask bit lands here
			MASKS: begin
				tag_nxt   = TAG_MASKS;
				data0_nxt = mask;
				data1_nxt = LABEL_W'(out_count);
				state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= IDLE;
			gid         <= '0;
			issue_valid <= 1'b0;
			tag         <= TAG_NONE;
			index0      <= '1;
			index1      <= '1;
		end else begin
			state       <= state_nxt;
			issue_valid <= accept;
			tag         <= tag_nxt;
			index0      <= index0_nxt;
			index1      <= index1_nxt;
			if (state == IDLE && start)
				gid <= '0;
			else if (accept)
				gid <= gid + WIRE_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		data0 <= data0_nxt;
		data1 <= data1_nxt;
		if (state == KEYS)
			r_label <= r_new;
		if (accept) begin
			issue_op        <= gate_op;
			issue_src0      <= gate_in0_pi ? SRC_INPUT : SRC_GATE;
			issue_src1      <= gate_in1_pi ? SRC_INPUT : SRC_GATE;
			issue_gid       <= gid;
			issue_is_output <= gate_is_output;
		end
	end

endmodule

`default_nettype wire

// File: garbler/label_store.sv
// Label memory with two write ports and two write-first synchronous read ports
// A written flag per entry tells whether a label exists yet, clr wipes all flags

`timescale 1ns/10ps
`default_nettype none

module label_store (
	input  logic         clk,
	input  logic         rst,
	label_port_if.store  port
);
	import gc_pkg::*;

	logic [LABEL_W-1:0]   mem [NUM_WIRES];
	logic [NUM_WIRES-1:0] written;

	// Written flags, cleared by reset and by clr
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			written <= '0;
		end else begin
			if (port.clr)
				written <= '0;
			if (port.wr_en0)
				written[port.wr_addr0] <= 1'b1; // A write in the clr cycle survives
			if (port.wr_en1)
				written[port.wr_addr1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (port.wr_en0)
			mem[port.wr_addr0] <= port.wr_data0;
		if (port.wr_en1)
			mem[port.wr_addr1] <= port.wr_data1;

		// Write-first bypass so back-to-back gates see fresh labels
		if (port.wr_en1 && port.wr_addr1 == port.rd_addr0)
			port.rd_data0 <= port.wr_data1;
		else if (port.wr_en0 && port.wr_addr0 == port.rd_addr0)
			port.rd_data0 <= port.wr_data0;
		else
			port.rd_data0 <= mem[port.rd_addr0];

		if (port.wr_en1 && port.wr_addr1 == port.rd_addr1)
			port.rd_data1 <= port.wr_data1;
		else if (port.wr_en0 && port.wr_addr0 == port.rd_addr1)
			port.rd_data1 <= port.wr_data0;
		else
			port.rd_data1 <= mem[port.rd_addr1];
	end

	assign port.written0 = written[port.rd_addr0];
	assign port.written1 = written[port.rd_addr1];

endmodule

`default_nettype wire

// File: garbler/label_gen.sv
// Two independent xorshift32 lanes producing wire labels
// label0/label1 show the current state, an enable moves its lane on at the edge

`timescale 1ns/10ps
`default_nettype none

module label_gen (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en0,
	input  logic                       en1,
	output logic [gc_pkg::LABEL_W-1:0] label0,
	output logic [gc_pkg::LABEL_W-1:0] label1
);
	import gc_pkg::*;

	logic [LABEL_W-1:0] lane0;
	logic [LABEL_W-1:0] lane1;

	// Shift triple 13, 17, 5
	function automatic logic [LABEL_W-1:0] xorshift32(input logic [LABEL_W-1:0] s);
		logic [LABEL_W-1:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane0 <= SEED0;
			lane1 <= SEED1;
		end else begin
			if (en0)
				lane0 <= xorshift32(lane0);
			if (en1)
				lane1 <= xorshift32(lane1);
		end
	end

	assign label0 = lane0;
	assign label1 = lane1; // Valid in the same cycle as the enable

endmodule

`default_nettype wire

// File: common/label_port_if.sv
// Write, read and written-flag signals of one label store
// The modports split the signals between the store, the control and the XOR unit

`timescale 1ns/10ps
`default_nettype none

interface label_port_if;
	import gc_pkg::*;

	logic               clr;
	logic               wr_en0;
	logic [WIRE_W-1:0]  wr_addr0;
	logic [LABEL_W-1:0] wr_data0;
	logic               wr_en1;
	logic [WIRE_W-1:0]  wr_addr1;
	logic [LABEL_W-1:0] wr_data1;
	logic [WIRE_W-1:0]  rd_addr0;
	logic [WIRE_W-1:0]  rd_addr1;
	logic [LABEL_W-1:0] rd_data0;
	logic [LABEL_W-1:0] rd_data1;
	logic               written0;
	logic               written1;

	modport store (input clr, wr_en0, wr_addr0, wr_data0, wr_en1, wr_addr1, wr_data1,
		input rd_addr0, rd_addr1, output rd_data0, rd_data1, written0, written1);

	// Writes plus read addresses, used where generation decides on the flags
	modport ctrl (output clr, wr_en0, wr_addr0, wr_data0, wr_en1, wr_addr1, wr_data1,
		output rd_addr0, rd_addr1, input written0, written1);

	modport writer (output clr, wr_en0, wr_addr0, wr_data0, wr_en1, wr_addr1, wr_data1,
		input written0, written1, rd_data0, rd_data1);

	modport rd_addr (output rd_addr0, rd_addr1);
	modport data (input rd_data0, rd_data1); // Read data only
endinterface

`default_nettype wire

// File: common/gc_pkg.sv
// Shared widths, seeds, store layout and enumerations for the free-XOR garbler
// Imported by every RTL block and by the testbench reference model

`default_nettype none

package gc_pkg;

	localparam int LABEL_W    = 32;  // Wire label width
	localparam int WIRE_W     = 8;   // Wire and gate index width
	localparam int NUM_WIRES  = 256; // Entries per label store
	localparam int MASK_IDX_W = $clog2(LABEL_W);

	// Input store layout, addresses 0 and 1 hold the constant labels
	localparam logic [WIRE_W-1:0] CONST_OFFSET = 8'd2;
	localparam logic [WIRE_W-1:0] CONST_ZERO   = 8'd254; // Maps to address 0
	localparam logic [WIRE_W-1:0] CONST_ONE    = 8'd255; // Maps to address 1

	// Lane start states, must be nonzero for xorshift
	localparam logic [LABEL_W-1:0] SEED0 = 32'h2545_f491;
	localparam logic [LABEL_W-1:0] SEED1 = 32'h9e37_79b9;

	typedef enum logic [1:0] {
		GATE_XOR  = 2'd0,
		GATE_XNOR = 2'd1,
		GATE_NOT  = 2'd2
	} gate_op_e;

	// Bit 2 set marks an input label record, bits 1:0 name the lanes
	typedef enum logic [2:0] {
		TAG_NONE  = 3'd0,
		TAG_KEYS  = 3'd1,
		TAG_MASKS = 3'd3,
		TAG_IN0   = 3'd5,
		TAG_IN1   = 3'd6,
		TAG_IN01  = 3'd7
	} tag_e;

	typedef enum {
		IDLE,
		KEYS,
		CONSTS,
		GARBLE,
		DRAIN,
		MASKS
	} ctrl_state_e;

	typedef enum logic {
		SRC_INPUT = 1'b0,
		SRC_GATE  = 1'b1
	} label_src_e;

endpackage

`default_nettype wire
